//--- vlog.f
+incdir+rtl
rtl/forth_pkg.sv
rtl/stack_if.sv
rtl/lifo_stack.sv
rtl/stack_sequencer.sv
rtl/forth_stack_core.sv
sim/tb_forth_stack.sv

//--- Bender.yml
package:
  name: forth_stack

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/forth_pkg.sv
      - rtl/stack_if.sv
      - rtl/lifo_stack.sv
      - rtl/stack_sequencer.sv
      - rtl/forth_stack_core.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_forth_stack.sv

//--- sim/tb_forth_stack.sv
/* self-checking testbench for the stack engine, LFSR stimulus against a queue model
   tos, nos and rs_top are compared only while the model holds those cells */
`timescale 1ns/1ps

`include "forth_defines.svh"

module tb_forth_stack
    import forth_pkg::*;
();

    localparam int DS         = `FORTH_DS_DEPTH;
    localparam int RS         = `FORTH_RS_DEPTH;
    localparam int N_RANDOM   = 600;
    localparam int N_WORDS    = N_RANDOM + 4 * DS + 6 * RS + 16; // bound over all phases
    localparam int MAX_CYCLES = 2 * N_WORDS + 200;

    logic    clk;
    logic    rst;
    logic    op_valid;
    opcode_e op;
    cell_t   lit;
    cell_t   tos;
    cell_t   nos;
    depth_t  ds_depth;
    cell_t   rs_top;
    depth_t  rs_depth;
    logic    err;

    cell_t       ds_q[$];          // model data stack, top at the back
    cell_t       rs_q[$];          // model return stack
    cell_t       exp_tos;
    cell_t       exp_nos;
    cell_t       exp_rs_top;
    depth_t      exp_ds_depth;
    depth_t      exp_rs_depth;
    logic        exp_err;
    cell_t       chk_tos;          // model state of the word strobed at the last edge
    cell_t       chk_nos;
    cell_t       chk_rs_top;
    depth_t      chk_ds_depth;
    depth_t      chk_rs_depth;
    logic        chk_err;
    logic        check_en;
    string       cur_word;         // word just driven
    string       chk_word;         // word whose result is checked next edge
    logic [31:0] lfsr_state;
    int          mismatch_count = 0;
    int          word_count     = 0;
    int          cycle_count    = 0;

    forth_stack_core uut (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .op       (op),
        .lit      (lit),
        .tos      (tos),
        .nos      (nos),
        .ds_depth (ds_depth),
        .rs_top   (rs_top),
        .rs_depth (rs_depth),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]}; // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("mismatch at %0t ns: %s after %s, expected %h, got %h",
                 $time, what, chk_word, expv, actv);
        mismatch_count++;
    endtask

    task automatic update_expected();
        exp_ds_depth = depth_t'(ds_q.size());
        exp_rs_depth = depth_t'(rs_q.size());
        if (ds_q.size() > 0) begin
            exp_tos = ds_q[$];
        end
        if (ds_q.size() > 1) begin
            exp_nos = ds_q[$-1];
        end
        if (rs_q.size() > 0) begin
            exp_rs_top = rs_q[$];
        end
    endtask

    // results become visible one edge after the strobe
    task automatic latch_expected();
        chk_tos      = exp_tos;
        chk_nos      = exp_nos;
        chk_rs_top   = exp_rs_top;
        chk_ds_depth = exp_ds_depth;
        chk_rs_depth = exp_rs_depth;
        chk_err      = exp_err;
        chk_word     = cur_word;
    endtask

    // legality table and word effects on the two queues
    task automatic apply_model(input logic valid, input opcode_e o, input cell_t l);
        int    d;
        int    r;
        logic  ok;
        cell_t a;
        cell_t b;
        d = ds_q.size();
        r = rs_q.size();
        case (o)
            op_lit:                         ok = (d < DS);
            op_drop:                        ok = (d >= 1);
            op_dup:                         ok = (d >= 1) && (d < DS);
            op_over:                        ok = (d >= 2) && (d < DS);
            op_swap, op_add, op_sub,
            op_and, op_xor:                 ok = (d >= 2);
            op_to_r:                        ok = (d >= 1) && (r < RS);
            op_from_r:                      ok = (r >= 1) && (d < DS);
            default:                        ok = 1'b1;
        endcase
        exp_err = valid && !ok;
        if (valid && ok) begin
            case (o)
                op_lit:    ds_q.push_back(l);
                op_drop:   a = ds_q.pop_back();
                op_dup:    ds_q.push_back(ds_q[d-1]);
                op_over:   ds_q.push_back(ds_q[d-2]);
                op_swap: begin
                    a = ds_q.pop_back();
                    b = ds_q.pop_back();
                    ds_q.push_back(a);
                    ds_q.push_back(b);
                end
                op_add, op_sub, op_and, op_xor: begin
                    a = ds_q.pop_back(); // tos
                    b = ds_q.pop_back(); // nos
                    case (o)
                        op_add:  ds_q.push_back(b + a);
                        op_sub:  ds_q.push_back(b - a);
                        op_and:  ds_q.push_back(b & a);
                        default: ds_q.push_back(b ^ a);
                    endcase
                end
                op_to_r:   rs_q.push_back(ds_q.pop_back());
                op_from_r: ds_q.push_back(rs_q.pop_back());
                default:   a = '0; // nop
            endcase
        end
        update_expected();
    endtask

    task automatic run_word(input logic valid, input opcode_e o, input cell_t l);
        @(posedge clk);
        #1;
        latch_expected();
        op_valid = valid;
        op       = o;
        lit      = l;
        if (valid) begin
            cur_word = o.name();
        end else begin
            cur_word = "idle";
        end
        apply_model(valid, o, l);
        word_count++;
    endtask

    task automatic push_random_lit();
        logic [31:0] v;
        draw_bits(32, v);
        run_word(1'b1, op_lit, v);
    endtask

    task automatic fill_and_drain_data();
        for (int i = 0; i < DS; i++) begin
            push_random_lit();
        end
        run_word(1'b1, op_lit, 32'hdead_beef); // full, all rejected
        run_word(1'b1, op_dup, '0);
        run_word(1'b1, op_over, '0);
        run_word(1'b1, op_from_r, '0);
        run_word(1'b0, op_lit, '0);
        for (int i = 0; i < DS; i++) begin
            run_word(1'b1, op_drop, '0);
        end
        run_word(1'b1, op_drop, '0); // empty, all rejected
        run_word(1'b1, op_swap, '0);
        run_word(1'b1, op_add, '0);
        run_word(1'b1, op_to_r, '0);
    endtask

    task automatic random_words(input int n);
        logic [31:0] v;
        logic [31:0] o_bits;
        logic [31:0] l;
        opcode_e     o;
        for (int i = 0; i < n; i++) begin
            draw_bits(1, v);
            draw_bits(4, o_bits);
            draw_bits(32, l);
            if (o_bits[3:0] > 4'(op_from_r)) begin
                o = op_nop;
            end else begin
                o = opcode_e'(o_bits[3:0]);
            end
            run_word(v[0], o, l);
        end
    endtask

    task automatic fill_and_drain_return();
        while (ds_q.size() > 0) begin
            run_word(1'b1, op_drop, '0);
        end
        for (int i = 0; i <= RS; i++) begin
            push_random_lit();
        end
        for (int i = 0; i < RS; i++) begin
            run_word(1'b1, op_to_r, '0);
        end
        run_word(1'b1, op_to_r, '0);   // return stack full
        for (int i = 0; i < RS; i++) begin
            run_word(1'b1, op_from_r, '0);
        end
        run_word(1'b1, op_from_r, '0); // return stack empty
    endtask

    // one comparison per edge, against the model state of the previous word
    a_ds_depth: assert property (@(posedge clk) check_en |-> ds_depth == chk_ds_depth)
        else report_mismatch("ds_depth", chk_ds_depth, $sampled(ds_depth));
    a_rs_depth: assert property (@(posedge clk) check_en |-> rs_depth == chk_rs_depth)
        else report_mismatch("rs_depth", chk_rs_depth, $sampled(rs_depth));
    a_err: assert property (@(posedge clk) check_en |-> err == chk_err)
        else report_mismatch("err", chk_err, $sampled(err));
    a_tos: assert property (@(posedge clk) check_en && chk_ds_depth >= 1 |-> tos == chk_tos)
        else report_mismatch("tos", chk_tos, $sampled(tos));
    a_nos: assert property (@(posedge clk) check_en && chk_ds_depth >= 2 |-> nos == chk_nos)
        else report_mismatch("nos", chk_nos, $sampled(nos));
    a_rs_top: assert property (@(posedge clk)
                               check_en && chk_rs_depth >= 1 |-> rs_top == chk_rs_top)
        else report_mismatch("rs_top", chk_rs_top, $sampled(rs_top));

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("summary: %0d words, %0d mismatches", word_count, mismatch_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        op_valid   = 1'b0;
        op         = op_nop;
        lit        = '0;
        check_en   = 1'b0;
        cur_word   = "reset";
        lfsr_state = 32'h97d0_b13d;
        exp_tos    = '0;
        exp_nos    = '0;
        exp_rs_top = '0;
        exp_err    = 1'b0;
        update_expected();
        latch_expected();
        repeat (8) @(posedge clk);
        #1;
        rst      = 1'b0;
        check_en = 1'b1; // first check sees the reset state
        fill_and_drain_data();
        random_words(N_RANDOM);
        fill_and_drain_return();
        run_word(1'b0, op_nop, '0);
        run_word(1'b0, op_nop, '0);
        @(posedge clk);
        #1;
        latch_expected();
        @(posedge clk); // last check fires here
        #1;
        $display("summary: %0d words, %0d mismatches", word_count, mismatch_count);
        if (mismatch_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- rtl/forth_stack_core.sv
/* stack engine top, data and return stacks plus the word sequencer
   one word per op_valid, no back-pressure, results visible the next cycle
   tos and rs_top hold stale values while their stack is empty */
`timescale 1ns/1ps

`include "forth_defines.svh"

module forth_stack_core
    import forth_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    op_valid,
    input  opcode_e op,
    input  cell_t   lit,
    output cell_t   tos,
    output cell_t   nos,
    output depth_t  ds_depth,
    output cell_t   rs_top,
    output depth_t  rs_depth,
    output logic    err
);

    stack_if ds_if ();
    stack_if rs_if ();

    // data stack
    lifo_stack #(
        .DEPTH (`FORTH_DS_DEPTH)
    ) u_ds (
        .clk (clk),
        .rst (rst),
        .s   (ds_if.slave)
    );

    // return stack
    lifo_stack #(
        .DEPTH (`FORTH_RS_DEPTH)
    ) u_rs (
        .clk (clk),
        .rst (rst),
        .s   (rs_if.slave)
    );

    stack_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .op       (op),
        .lit      (lit),
        .ds       (ds_if.master),
        .rs       (rs_if.master),
        .err      (err)
    );

    assign tos      = ds_if.tos;
    assign nos      = ds_if.nos;
    assign ds_depth = ds_if.depth;
    assign rs_top   = rs_if.tos;
    assign rs_depth = rs_if.depth;

endmodule

//--- rtl/stack_sequencer.sv
/* one word per op_valid strobe, decoded combinationally into stack commands
   words that would break either stack are dropped and flag err for one cycle */
`timescale 1ns/1ps

module stack_sequencer
    import forth_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     op_valid,
    input  opcode_e  op,
    input  cell_t    lit,
    stack_if.master  ds,
    stack_if.master  rs,
    output logic     err
);

    stack_cmd_e ds_cmd;
    stack_cmd_e rs_cmd;
    cell_t      ds_wdata;
    cell_t      rs_wdata;
    cell_t      alu_res;
    depth_t     need_d;  // data cells the word consumes
    logic       need_r;  // word pops the return stack
    logic       grow_d;  // word pushes the data stack
    logic       grow_r;  // word pushes the return stack
    logic       legal;

    // nos op tos for the binary words
    always_comb begin
        case (op)
            op_add: begin
                alu_res = ds.nos + ds.tos;
            end
            op_sub: begin
                alu_res = ds.nos - ds.tos; // wraps modulo cell width
            end
            op_and: begin
                alu_res = ds.nos & ds.tos;
            end
            op_xor: begin
                alu_res = ds.nos ^ ds.tos;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // word decode, requirements and per-stack command
    always_comb begin
        ds_cmd   = sc_none;
        rs_cmd   = sc_none;
        ds_wdata = lit;
        rs_wdata = ds.tos;
        need_d   = '0;
        need_r   = 1'b0;
        grow_d   = 1'b0;
        grow_r   = 1'b0;
        case (op)
            op_lit: begin
                ds_cmd = sc_push;
                grow_d = 1'b1;
            end
            op_drop: begin
                ds_cmd = sc_pop;
                need_d = depth_t'(1);
            end
            op_dup: begin
                ds_cmd   = sc_push;
                ds_wdata = ds.tos;
                need_d   = depth_t'(1);
                grow_d   = 1'b1;
            end
            op_over: begin
                ds_cmd   = sc_push;
                ds_wdata = ds.nos;
                need_d   = depth_t'(2);
                grow_d   = 1'b1;
            end
            op_swap: begin
                ds_cmd = sc_swap;
                need_d = depth_t'(2);
            end
            op_add, op_sub, op_and, op_xor: begin
                ds_cmd   = sc_pop_set;
                ds_wdata = alu_res;
                need_d   = depth_t'(2);
            end
            op_to_r: begin
                ds_cmd = sc_pop;
                rs_cmd = sc_push; // rs_wdata already carries tos
                need_d = depth_t'(1);
                grow_r = 1'b1;
            end
            op_from_r: begin
                ds_cmd   = sc_push;
                ds_wdata = rs.tos;
                rs_cmd   = sc_pop;
                need_r   = 1'b1;
                grow_d   = 1'b1;
            end
            default: begin
                ds_cmd = sc_none; // nop and unused codes
            end
        endcase
    end

    assign legal = (ds.depth >= need_d)
                 && !(need_r && rs.empty)
                 && !(grow_d && ds.full)
                 && !(grow_r && rs.full);

    // rejected or idle cycles leave both stacks alone
    assign ds.cmd   = (op_valid && legal) ? ds_cmd : sc_none;
    assign rs.cmd   = (op_valid && legal) ? rs_cmd : sc_none;
    assign ds.wdata = ds_wdata;
    assign rs.wdata = rs_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            err <= 1'b0;
        end else begin
            err <= op_valid && !legal; // high the cycle after a rejected word
        end
    end

endmodule

//--- rtl/lifo_stack.sv
/* lifo with the top cell in a register and the rest in an array
   commands are obeyed unchecked, the sequencer keeps them legal
   DEPTH must be a power of two, tos is undefined while empty */
`timescale 1ns/1ps

module lifo_stack
    import forth_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input logic    clk,
    input logic    rst,
    stack_if.slave s
);

    localparam int AW = $clog2(DEPTH);

    cell_t         mem [DEPTH]; // top slot never read, keeps indices in range
    cell_t         top_q;
    depth_t        count_q;     // cells held, top included
    logic [AW-1:0] below_ptr;   // where the old top goes on push
    logic [AW-1:0] nos_ptr;     // cell under the top

    // modulo AW arithmetic, so a full count wraps to the right slot
    assign below_ptr = count_q[AW-1:0] - AW'(1);
    assign nos_ptr   = count_q[AW-1:0] - AW'(2);

    // occupancy counter
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            case (s.cmd)
                sc_push: begin
                    count_q <= count_q + depth_t'(1);
                end
                sc_pop, sc_pop_set: begin
                    count_q <= count_q - depth_t'(1);
                end
                default: begin
                    count_q <= count_q; // set_top and swap keep the count
                end
            endcase
        end
    end

    // top register and cell array
    always_ff @(posedge clk) begin
        case (s.cmd)
            sc_push: begin
                if (count_q != '0) begin
                    mem[below_ptr] <= top_q; // nothing to sink when empty
                end
                top_q <= s.wdata;
            end
            sc_pop: begin
                top_q <= mem[nos_ptr];
            end
            sc_set_top, sc_pop_set: begin
                top_q <= s.wdata;
            end
            sc_swap: begin
                mem[nos_ptr] <= top_q;
                top_q        <= mem[nos_ptr];
            end
            default: begin
                top_q <= top_q;
            end
        endcase
    end

    assign s.tos   = top_q;
    assign s.nos   = mem[nos_ptr]; // async read below the top
    assign s.depth = count_q;
    assign s.empty = (count_q == '0);
    assign s.full  = (count_q == depth_t'(DEPTH));

endmodule

//--- rtl/stack_if.sv
/* link between the sequencer and one stack
   cmd is a one-cycle strobe, the stack acts on it at the next edge */
`timescale 1ns/1ps

interface stack_if
    import forth_pkg::*;
();

    stack_cmd_e cmd;   // sc_none when idle
    cell_t      wdata; // push value or new top

    cell_t      tos;   // registered top cell
    cell_t      nos;   // cell just below the top
    depth_t     depth; // cells held
    logic       empty;
    logic       full;

    modport master (
        output cmd,
        output wdata,
        input  tos,
        input  nos,
        input  depth,
        input  empty,
        input  full
    );

    modport slave (
        input  cmd,
        input  wdata,
        output tos,
        output nos,
        output depth,
        output empty,
        output full
    );

endinterface

//--- rtl/forth_pkg.sv
/* shared types for the stack engine
   depth_t holds counts from 0 up to the data stack depth */
`include "forth_defines.svh"

package forth_pkg;

    localparam int DEPTH_W = $clog2(`FORTH_DS_DEPTH + 1); // 5 bits for 16 cells

    typedef logic [`FORTH_CELL_W-1:0] cell_t;
    typedef logic [DEPTH_W-1:0]       depth_t;

    typedef enum logic [3:0] {
        op_nop    = 4'd0,
        op_lit    = 4'd1,
        op_drop   = 4'd2,
        op_dup    = 4'd3,
        op_swap   = 4'd4,
        op_over   = 4'd5,
        op_add    = 4'd6,
        op_sub    = 4'd7,
        op_and    = 4'd8,
        op_xor    = 4'd9,
        op_to_r   = 4'd10, // >r
        op_from_r = 4'd11  // r>, codes above this are unused
    } opcode_e;

    typedef enum logic [2:0] {
        sc_none    = 3'd0,
        sc_push    = 3'd1, // old top sinks into memory
        sc_pop     = 3'd2, // top reloads from memory
        sc_set_top = 3'd3,
        sc_pop_set = 3'd4, // drop top, overwrite new top
        sc_swap    = 3'd5
    } stack_cmd_e;

endpackage

//--- rtl/forth_defines.svh
/* build-wide sizes for the stack engine
   the data stack must stay the deeper of the two stacks, because depth_t is sized from it
   both depths must be powers of two no larger than 16 */
`ifndef FORTH_DEFINES_SVH
`define FORTH_DEFINES_SVH

// width of one stack cell in bits
`define FORTH_CELL_W 32

// data stack cells, including the cached top
`define FORTH_DS_DEPTH 16

// return stack cells, including the cached top
`define FORTH_RS_DEPTH 8

`endif
